// File: source/eth_tx_pkg.sv
package eth_tx_pkg;

  // Frame layout
  localparam int PRE_LEN     = 8;                    // 7 x 0x55 then SFD
  localparam int HDR_LEN     = 22;                   // Preamble, dst, src, ethertype
  localparam int MIN_PLD_LEN = 46;
  localparam int FCS_LEN     = 4;

  localparam logic [8*PRE_LEN-1:0] PREAMBLE = 64'h55_55_55_55_55_55_55_d5;

  // Payload buffer
  localparam int FIFO_DEPTH = 2048;
  localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

  // CRC-32, reflected form
  localparam logic [31:0] CRC_POLY = 32'hedb8_8320;
  localparam logic [31:0] CRC_INIT = 32'hffff_ffff;

  typedef logic [10:0] length_t;    // Payload length, 1 to 1500
  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] crc_t;

  // Header seen as fields when loaded, as bytes when sent
  typedef union packed {
    struct packed {
      logic [8*PRE_LEN-1:0] pre;
      mac_addr_t            dst;
      mac_addr_t            src;
      logic [15:0]          ethertype;
    } fld;
    logic [0:HDR_LEN-1][7:0] bytes;  // bytes[0] goes out first
  } mac_hdr_u;

endpackage

// File: source/eth_crc32.sv
`timescale 1ns/1ps

module eth_crc32 (
  input  logic             clk,
  input  logic             fsm_rst,
  input  logic             crc_clr,
  input  logic             crc_en,
  input  byte              crc_dat,
  output eth_tx_pkg::crc_t crc_val
);
  import eth_tx_pkg::*;

  // Folds one byte into the running CRC, LSB first
  function automatic crc_t crc_byte(crc_t c, logic [7:0] d);
    crc_t r;
    r = c;
    for (int i = 0; i < 8; i++) begin
      if (r[0] ^ d[i]) begin
        r = (r >> 1) ^ CRC_POLY;
      end else begin
        r = r >> 1;
      end
    end
    return r;
  endfunction

  always_ff @(posedge clk) begin
    if (fsm_rst || crc_clr) begin
      crc_val <= CRC_INIT;
    end else if (crc_en) begin
      crc_val <= crc_byte(crc_val, crc_dat);
    end
  end

endmodule

// File: source/eth_tx_payload_fifo.sv
`timescale 1ns/1ps

module eth_tx_payload_fifo (
  input  logic clk,
  input  logic fsm_rst,
  input  logic pld_wr,
  input  byte  pld_dat,
  input  logic pld_rd,
  output byte  pld_q,
  output logic pld_full,
  output logic pld_underrun
);
  import eth_tx_pkg::*;

  logic [7:0]         mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_AW:0]   cnt;        // Occupancy, 0 to FIFO_DEPTH
  logic               empty;
  logic               wr_ok;
  logic               rd_ok;

  assign empty    = (cnt == '0);
  assign pld_full = (cnt == (FIFO_AW+1)'(FIFO_DEPTH));
  assign wr_ok    = pld_wr && !pld_full;   // Writes on full are lost
  assign rd_ok    = pld_rd && !empty;

  always_ff @(posedge clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= pld_dat;
    end
    if (pld_rd) begin
      pld_q <= rd_ok ? mem[rd_ptr] : 8'h00;  // Empty read gives zero
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      cnt          <= '0;
      pld_underrun <= 1'b0;
    end else begin
      if (wr_ok) begin
        wr_ptr <= wr_ptr + 1'b1;    // Wraps at FIFO_DEPTH
      end
      if (rd_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (pld_rd && empty) begin
        pld_underrun <= 1'b1;       // Sticky until fsm_rst
      end
      case ({wr_ok, rd_ok})
        2'b10:   cnt <= cnt + 1'b1;
        2'b01:   cnt <= cnt - 1'b1;
        default: cnt <= cnt;
      endcase
    end
  end

endmodule

// File: source/eth_tx_framer.sv
`timescale 1ns/1ps

module eth_tx_framer (
  input  logic                  clk,
  input  logic                  fsm_rst,
  input  logic                  tx_rdy,
  input  eth_tx_pkg::mac_addr_t tx_dst,
  input  logic [15:0]           tx_type,
  input  eth_tx_pkg::length_t   tx_len,
  input  eth_tx_pkg::mac_addr_t dev_mac,
  output logic                  tx_acc,
  output logic                  tx_done,
  output logic                  pld_rd,
  input  byte                   pld_q,
  output logic                  crc_clr,
  output logic                  crc_en,
  output byte                   crc_dat,
  input  eth_tx_pkg::crc_t      crc_val,
  output logic                  phy_val,
  output byte                   phy_dat
);
  import eth_tx_pkg::*;

  enum logic [1:0] {
    IDLE_S,
    HDR_S,
    PLD_S,
    FCS_S
  } state;

  logic                       frame_rst;
  mac_hdr_u                   hdr_q;
  length_t                    cur_len;
  length_t                    pld_cnt;
  length_t                    pld_next;
  length_t                    rd_left;     // Buffer reads still to issue
  logic [$clog2(HDR_LEN)-1:0] hdr_cnt;
  logic [1:0]                 fcs_cnt;
  logic                       fcs_on;
  logic                       pld_last;
  logic                       rd_win;
  logic [7:0]                 dat_q;
  crc_t                       fcs_word;

  assign frame_rst = fsm_rst || tx_done;  // Back to idle after every frame

  assign pld_next = pld_cnt + 1'b1;

  // Last payload byte once both the length and the minimum are covered
  assign pld_last = (pld_next >= cur_len) && (pld_next >= length_t'(MIN_PLD_LEN));

  // pld_q is sampled a cycle after pld_rd and shown a cycle after that,
  // so reads start two bytes before the end of the header
  assign rd_win = (state == HDR_S && hdr_cnt >= HDR_LEN - 2) || (state == PLD_S);

  always_ff @(posedge clk) begin
    if (frame_rst) begin
      state   <= IDLE_S;
      tx_acc  <= 1'b0;
      tx_done <= 1'b0;
      phy_val <= 1'b0;
      pld_rd  <= 1'b0;
      crc_en  <= 1'b0;
      fcs_on  <= 1'b0;
      rd_left <= '0;
      hdr_cnt <= '0;
      pld_cnt <= '0;
      fcs_cnt <= '0;
    end else begin
      tx_acc <= 1'b0;
      pld_rd <= 1'b0;
      if (rd_win && rd_left != '0) begin
        pld_rd  <= 1'b1;
        rd_left <= rd_left - 1'b1;
      end
      case (state)
        IDLE_S: begin
          if (tx_rdy) begin
            tx_acc  <= 1'b1;
            rd_left <= tx_len;
            state   <= HDR_S;
          end
        end
        HDR_S: begin
          phy_val <= 1'b1;
          hdr_cnt <= hdr_cnt + 1'b1;
          if (hdr_cnt == PRE_LEN) crc_en <= 1'b1;   // First destination byte
          if (hdr_cnt == HDR_LEN - 1) state <= PLD_S;
        end
        PLD_S: begin
          pld_cnt <= pld_next;
          if (pld_last) state <= FCS_S;
        end
        FCS_S: begin
          if (!fcs_on) begin
            // CRC takes the last pad byte on this edge
            fcs_on <= 1'b1;
            crc_en <= 1'b0;
          end else if (fcs_cnt == FCS_LEN - 1) begin
            phy_val <= 1'b0;
            fcs_on  <= 1'b0;
            tx_done <= 1'b1;
          end else begin
            fcs_cnt <= fcs_cnt + 1'b1;
          end
        end
        default: state <= IDLE_S;
      endcase
    end
  end

  // Header and byte datapath
  always_ff @(posedge clk) begin
    case (state)
      IDLE_S: begin
        if (tx_rdy) begin
          cur_len                 <= tx_len;
          hdr_q.fld.pre           <= PREAMBLE;
          hdr_q.fld.dst           <= tx_dst;
          hdr_q.fld.src           <= dev_mac;
          hdr_q.fld.ethertype     <= tx_type;
        end
      end
      HDR_S: begin
        dat_q       <= hdr_q.bytes[0];
        hdr_q.bytes <= {hdr_q.bytes[1:HDR_LEN-1], 8'h00};
      end
      PLD_S: begin
        dat_q <= (pld_cnt < cur_len) ? pld_q : 8'h00;  // Zero pad
      end
      default: dat_q <= dat_q;
    endcase
  end

  assign crc_clr  = tx_acc;
  assign crc_dat  = dat_q;
  assign fcs_word = ~crc_val;

  // FCS goes out straight from the CRC register, low byte first
  assign phy_dat = fcs_on ? fcs_word[8*fcs_cnt +: 8] : dat_q;

endmodule

// File: source/eth_tx_top.sv
`timescale 1ns/1ps

module eth_tx_top (
  input  logic                  clk,
  input  logic                  fsm_rst,
  input  logic                  pld_wr,
  input  byte                   pld_dat,
  output logic                  pld_full,
  input  logic                  tx_rdy,
  input  eth_tx_pkg::mac_addr_t tx_dst,
  input  logic [15:0]           tx_type,
  input  eth_tx_pkg::length_t   tx_len,
  output logic                  tx_acc,
  output logic                  tx_done,
  input  eth_tx_pkg::mac_addr_t dev_mac,
  output logic                  phy_val,
  output byte                   phy_dat,
  output logic                  pld_underrun
);
  import eth_tx_pkg::*;

  logic pld_rd;
  byte  pld_q;
  logic crc_clr;
  logic crc_en;
  byte  crc_dat;
  crc_t crc_val;

  eth_tx_payload_fifo eth_tx_payload_fifo_inst (
    .clk          (clk),
    .fsm_rst      (fsm_rst),
    .pld_wr       (pld_wr),
    .pld_dat      (pld_dat),
    .pld_rd       (pld_rd),
    .pld_q        (pld_q),
    .pld_full     (pld_full),
    .pld_underrun (pld_underrun)
  );

  eth_tx_framer eth_tx_framer_inst (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .tx_rdy  (tx_rdy),
    .tx_dst  (tx_dst),
    .tx_type (tx_type),
    .tx_len  (tx_len),
    .dev_mac (dev_mac),
    .tx_acc  (tx_acc),
    .tx_done (tx_done),
    .pld_rd  (pld_rd),
    .pld_q   (pld_q),
    .crc_clr (crc_clr),
    .crc_en  (crc_en),
    .crc_dat (crc_dat),
    .crc_val (crc_val),
    .phy_val (phy_val),
    .phy_dat (phy_dat)
  );

  eth_crc32 eth_crc32_inst (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .crc_clr (crc_clr),
    .crc_en  (crc_en),
    .crc_dat (crc_dat),
    .crc_val (crc_val)
  );

endmodule

// File: verif/eth_tx_checker.sv
`timescale 1ns/1ps

module eth_tx_checker (
  input logic clk,
  input logic fsm_rst,
  input logic tx_acc,
  input logic tx_done,
  input logic phy_val
);

  int fail_cnt = 0;  // Failed assertions so far

  acc_pulse: assert property (@(posedge clk) disable iff (fsm_rst) tx_acc |=> !tx_acc)
    else begin
      $error("tx_acc stayed high for more than one cycle");
      fail_cnt++;
    end

  done_pulse: assert property (@(posedge clk) disable iff (fsm_rst) tx_done |=> !tx_done)
    else begin
      $error("tx_done stayed high for more than one cycle");
      fail_cnt++;
    end

  // Frame starts right after acceptance and runs without gaps
  val_start: assert property (@(posedge clk) disable iff (fsm_rst) tx_acc |=> phy_val)
    else begin
      $error("phy_val did not rise after tx_acc");
      fail_cnt++;
    end

  val_held: assert property (@(posedge clk) disable iff (fsm_rst)
                             phy_val |=> (phy_val || tx_done))
    else begin
      $error("phy_val dropped before tx_done");
      fail_cnt++;
    end

  no_acc_busy: assert property (@(posedge clk) disable iff (fsm_rst)
                                (phy_val || tx_done) |-> !tx_acc)
    else begin
      $error("tx_acc while a frame was in flight");
      fail_cnt++;
    end

endmodule

bind eth_tx_top eth_tx_checker eth_tx_checker_inst (
  .clk     (clk),
  .fsm_rst (fsm_rst),
  .tx_acc  (tx_acc),
  .tx_done (tx_done),
  .phy_val (phy_val)
);

// File: verif/eth_tx_tb.sv
`timescale 1ns/1ps

module eth_tx_tb;
  import eth_tx_pkg::*;

  localparam int          NUM_FRAMES = 40;
  localparam int          MAX_CYCLES = (NUM_FRAMES + 1) * (1530 + 1500 + 50);
  localparam logic [31:0] SEED       = 32'h27e6_52c0;
  localparam mac_addr_t   DEV_MAC    = 48'h02_00_5e_10_20_30;

  logic        clk;
  logic        fsm_rst;
  logic        pld_wr;
  byte         pld_dat;
  logic        pld_full;
  logic        tx_rdy;
  mac_addr_t   tx_dst;
  logic [15:0] tx_type;
  length_t     tx_len;
  logic        tx_acc;
  logic        tx_done;
  mac_addr_t   dev_mac;
  logic        phy_val;
  byte         phy_dat;
  logic        pld_underrun;

  byte     exp_q[$];   // Expected bytes up to the last pad byte
  length_t len_q[$];   // Expected frame length on the wire
  crc_t    fcs_q[$];
  crc_t    fcs_rx;     // Last four bytes seen, low byte first
  int      rx_idx   = 0;
  int      done_cnt = 0;
  int      acc_cnt  = 0;
  int      cycles   = 0;
  logic    prev_acc = 1'b0;
  logic    prev_val = 1'b0;
  int      err_byte = 0;
  int      err_fcs  = 0;
  int      err_len  = 0;
  int      err_flag = 0;
  int      err_seq  = 0;

  eth_tx_top eth_tx_top_inst (
    .clk          (clk),
    .fsm_rst      (fsm_rst),
    .pld_wr       (pld_wr),
    .pld_dat      (pld_dat),
    .pld_full     (pld_full),
    .tx_rdy       (tx_rdy),
    .tx_dst       (tx_dst),
    .tx_type      (tx_type),
    .tx_len       (tx_len),
    .tx_acc       (tx_acc),
    .tx_done      (tx_done),
    .dev_mac      (dev_mac),
    .phy_val      (phy_val),
    .phy_dat      (phy_dat),
    .pld_underrun (pld_underrun)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Reflected CRC-32, byte xored into the low bits then shifted out
  function automatic crc_t crc_add_byte(crc_t c, byte b);
    crc_t r;
    r = c ^ {24'h0, b};
    for (int k = 0; k < 8; k++) begin
      r = r[0] ? ((r >> 1) ^ CRC_POLY) : (r >> 1);
    end
    return r;
  endfunction

  function automatic int total_errors();
    return err_byte + err_fcs + err_len + err_flag + err_seq +
           eth_tx_top_inst.eth_tx_checker_inst.fail_cnt;
  endfunction

  task automatic check_byte(input byte got, input byte exp);
    if (got !== exp) begin
      err_byte++;
      $display("** Error @ %0t: frame %0d byte %0d is %02h, expected %02h",
               $time, done_cnt, rx_idx, got, exp);
    end
  endtask

  task automatic check_fcs(input crc_t got, input crc_t exp);
    if (got !== exp) begin
      err_fcs++;
      $display("** Error @ %0t: frame %0d FCS is %08h, expected %08h",
               $time, done_cnt, got, exp);
    end
  endtask

  task automatic check_len(input length_t got, input length_t exp);
    if (got !== exp) begin
      err_len++;
      $display("** Error @ %0t: frame %0d has %0d bytes, expected %0d",
               $time, done_cnt, got, exp);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      err_flag++;
      $display("** Error @ %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic print_counts();
    $display("errors: byte %0d, fcs %0d, length %0d, control %0d, sequence %0d, assertion %0d",
             err_byte, err_fcs, err_len, err_flag, err_seq,
             eth_tx_top_inst.eth_tx_checker_inst.fail_cnt);
  endtask

  task automatic check_reset_state();
    check_flag("tx_acc after reset", tx_acc, 1'b0);
    check_flag("tx_done after reset", tx_done, 1'b0);
    check_flag("phy_val after reset", phy_val, 1'b0);
    check_flag("pld_underrun after reset", pld_underrun, 1'b0);
    check_flag("pld_full after reset", pld_full, 1'b0);
    check_flag("pld_rd after reset", eth_tx_top_inst.pld_rd, 1'b0);
    check_flag("crc_en after reset", eth_tx_top_inst.crc_en, 1'b0);
  endtask

  // Queues the expected frame, loads keep bytes, then waits for acceptance
  task automatic send_frame(input length_t len, input int keep);
    mac_hdr_u    hdr;
    mac_addr_t   dst;
    logic [15:0] etype;
    byte         data[$];
    crc_t        crc;
    int          n_body;
    byte         b;
    dst   = mac_addr_t'({$urandom, $urandom});
    etype = 16'($urandom);
    for (int i = 0; i < keep; i++) begin
      data.push_back(byte'($urandom));
    end
    hdr.fld.pre       = PREAMBLE;
    hdr.fld.dst       = dst;
    hdr.fld.src       = DEV_MAC;
    hdr.fld.ethertype = etype;
    crc = CRC_INIT;
    for (int i = 0; i < HDR_LEN; i++) begin
      exp_q.push_back(hdr.bytes[i]);
      if (i >= PRE_LEN) crc = crc_add_byte(crc, hdr.bytes[i]);  // FCS starts at dst
    end
    n_body = (len < MIN_PLD_LEN) ? MIN_PLD_LEN : int'(len);
    for (int i = 0; i < n_body; i++) begin
      b = (i < keep) ? data[i] : 8'h00;  // Pad and missing data read as zero
      exp_q.push_back(b);
      crc = crc_add_byte(crc, b);
    end
    len_q.push_back(length_t'(HDR_LEN + n_body + FCS_LEN));
    fcs_q.push_back(~crc);
    foreach (data[i]) begin
      if ($urandom % 8 == 0) begin
        pld_wr <= 1'b0;
        repeat (1 + $urandom % 4) @(posedge clk);
      end
      pld_wr  <= 1'b1;
      pld_dat <= data[i];
      @(posedge clk);
    end
    pld_wr  <= 1'b0;
    tx_rdy  <= 1'b1;
    tx_dst  <= dst;
    tx_type <= etype;
    tx_len  <= len;
    do @(posedge clk); while (tx_acc !== 1'b1);
    tx_rdy <= 1'b0;
  endtask

  task automatic take_byte(input byte b);
    int n_data;
    if (len_q.size() == 0) begin
      err_seq++;
      $display("byte %02h sent at %0t while no frame was expected", b, $time);
    end else begin
      n_data = int'(len_q[0]) - FCS_LEN;
      if (rx_idx < n_data) check_byte(b, exp_q.pop_front());
      fcs_rx = {b, fcs_rx[31:8]};
    end
    rx_idx++;
  endtask

  task automatic close_frame();
    int n_data;
    if (len_q.size() == 0) begin
      err_seq++;
      $display("tx_done at %0t while no frame was expected", $time);
    end else begin
      n_data = int'(len_q[0]) - FCS_LEN;
      if (rx_idx < n_data) begin
        err_seq++;
        $display("frame %0d ended %0d bytes early", done_cnt, n_data - rx_idx);
        repeat (n_data - rx_idx) void'(exp_q.pop_front());
      end else if (rx_idx > n_data + FCS_LEN) begin
        err_seq++;
        $display("frame %0d carried %0d extra bytes", done_cnt, rx_idx - n_data - FCS_LEN);
      end
      check_len(length_t'(rx_idx), len_q.pop_front());
      check_fcs(fcs_rx, fcs_q.pop_front());
    end
    done_cnt++;
    rx_idx = 0;
  endtask

  // Monitor
  always @(posedge clk) begin
    if (fsm_rst) begin
      rx_idx   = 0;
      prev_acc = 1'b0;
      prev_val = 1'b0;
    end else begin
      if (pld_wr && pld_full) begin
        err_seq++;
        $display("payload write at %0t was dropped on a full buffer", $time);
      end
      if (prev_acc) check_flag("phy_val after tx_acc", phy_val, 1'b1);
      if (tx_acc) acc_cnt++;
      if (phy_val) take_byte(phy_dat);
      if (tx_done) begin
        check_flag("phy_val with tx_done", phy_val, 1'b0);
        check_flag("phy_val before tx_done", prev_val, 1'b1);
        close_frame();
      end
      prev_acc = tx_acc;
      prev_val = phy_val;
    end
  end

  initial begin
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run stopped after %0d cycles with %0d of %0d frames done",
             cycles, done_cnt, NUM_FRAMES + 1);
    print_counts();
    $display("test failed");
    $finish;
  end

  // Driver
  initial begin
    length_t len;
    int      keep;
    void'($urandom(SEED));
    fsm_rst = 1'b1;
    pld_wr  = 1'b0;
    pld_dat = 8'h00;
    tx_rdy  = 1'b0;
    tx_dst  = '0;
    tx_type = '0;
    tx_len  = '0;
    dev_mac = DEV_MAC;
    repeat (5) @(posedge clk);
    fsm_rst <= 1'b0;
    @(posedge clk);
    check_reset_state();
    for (int f = 0; f < NUM_FRAMES; f++) begin
      if ($urandom % 3 == 0) begin
        len = length_t'(1 + $urandom % (MIN_PLD_LEN - 1));  // Needs padding
      end else begin
        len = length_t'(MIN_PLD_LEN + $urandom % (1501 - MIN_PLD_LEN));
      end
      send_frame(len, int'(len));
    end
    wait (done_cnt == NUM_FRAMES);
    @(posedge clk);
    check_flag("pld_underrun before the short frame", pld_underrun, 1'b0);
    len  = length_t'(60 + $urandom % 100);
    keep = 10 + $urandom % 20;   // Buffer runs dry mid-payload
    send_frame(len, keep);
    wait (done_cnt == NUM_FRAMES + 1);
    repeat (2) @(posedge clk);
    check_flag("pld_underrun after the short frame", pld_underrun, 1'b1);
    if (acc_cnt != NUM_FRAMES + 1) begin
      err_seq++;
      $display("tx_acc came %0d times for %0d frames", acc_cnt, NUM_FRAMES + 1);
    end
    if (len_q.size() != 0 || exp_q.size() != 0) begin
      err_seq++;
      $display("%0d expected frames were never sent", len_q.size());
    end
    print_counts();
    if (total_errors() == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: eth_tx_top.f
source/eth_tx_pkg.sv
source/eth_crc32.sv
source/eth_tx_payload_fifo.sv
source/eth_tx_framer.sv
source/eth_tx_top.sv
verif/eth_tx_checker.sv
verif/eth_tx_tb.sv

// File: Bender.yml
package:
  name: eth_tx

sources:
  - files:
      - source/eth_tx_pkg.sv
      - source/eth_crc32.sv
      - source/eth_tx_payload_fifo.sv
      - source/eth_tx_framer.sv
      - source/eth_tx_top.sv
  - target: test
    files:
      - verif/eth_tx_checker.sv
      - verif/eth_tx_tb.sv
